//--- Makefile
# Verilator flow for the load-store unit

TOP := tb_lsu

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module lsu_top \
		lsu_pkg.sv lsu_decode.sv lsu_mem_access.sv lsu_result.sv lsu_top.sv

# The run passes only if the log holds the pass line
sim:
	verilator --binary --assert --top-module $(TOP) -f filelist.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
lsu_pkg.sv
lsu_decode.sv
lsu_mem_access.sv
lsu_result.sv
lsu_top.sv
tb_lsu.sv

//--- lsu_decode.sv
/*
 * LSU decode stage
 * Issue handshake, address generation, byte enables, alignment
 * and range checks, registered request towards execute
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_decode #(
  parameter int unsigned MEM_BYTES = lsu_pkg::MEM_BYTES
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  lsu_pkg::lsu_op_e    op_i,
  input  lsu_pkg::word_t      operand_a_i,
  input  lsu_pkg::word_t      operand_b_i,
  input  lsu_pkg::word_t      imm_i,
  input  lsu_pkg::trans_id_t  trans_id_i,
  output logic                req_valid_o,
  output logic                req_we_o,
  output lsu_pkg::lsu_op_e    req_op_o,
  output lsu_pkg::word_t      req_addr_o,
  output lsu_pkg::be_t        req_be_o,
  output lsu_pkg::word_t      req_wdata_o,
  output lsu_pkg::trans_id_t  req_trans_id_o,
  output logic                req_ex_valid_o,
  output lsu_pkg::cause_t     req_ex_cause_o
);

  lsu_pkg::word_t   addr;
  lsu_pkg::size_e   size;
  lsu_pkg::be_t     be;
  lsu_pkg::word_t   wdata;
  lsu_pkg::cause_t  cause;
  logic             is_store;
  logic             misaligned;
  logic             out_of_range;
  logic             fault;
  logic             accept;
  logic             init_done_q;

  // Issue handshake
  // Ready comes up one cycle after reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_done_q <= 1'b0;
    end else begin
      init_done_q <= 1'b1;
    end
  end

  assign ready_o = init_done_q & ~flush_i;
  assign accept  = valid_i & ready_o;

  // ------------------------------------------------
  // Address generation and byte lanes
  // ------------------------------------------------
  assign addr     = operand_a_i + imm_i;
  assign size     = lsu_pkg::op_size(op_i);
  assign is_store = lsu_pkg::op_is_store(op_i);
  assign wdata    = operand_b_i << {addr[1:0], 3'b000};

  always_comb begin
    misaligned = 1'b0;
    be         = '0;
    case (size)
      lsu_pkg::SIZE_BYTE: begin
        be = lsu_pkg::be_t'(4'b0001 << addr[1:0]);
      end
      lsu_pkg::SIZE_HALF: begin
        misaligned = addr[0];
        be         = lsu_pkg::be_t'(4'b0011 << addr[1:0]);
      end
      default: begin
        misaligned = |addr[1:0];
        be         = '1;
      end
    endcase
  end

  // ------------------------------------------------
  // Exception detection
  // ------------------------------------------------
  assign out_of_range = addr >= lsu_pkg::word_t'(MEM_BYTES);
  assign fault        = misaligned | out_of_range;

  // Misalignment wins over the access fault
  always_comb begin
    if (misaligned) begin
      cause = is_store ? lsu_pkg::CAUSE_ST_MISALIGNED : lsu_pkg::CAUSE_LD_MISALIGNED;
    end else if (out_of_range) begin
      cause = is_store ? lsu_pkg::CAUSE_ST_ACCESS : lsu_pkg::CAUSE_LD_ACCESS;
    end else begin
      cause = '0;
    end
  end

  // Request register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_o    <= 1'b0;
      req_ex_valid_o <= 1'b0;
    end else begin
      req_valid_o    <= accept;
      req_ex_valid_o <= accept & fault;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_we_o       <= is_store;
      req_op_o       <= op_i;
      req_addr_o     <= addr;
      req_be_o       <= fault ? '0 : be;
      req_wdata_o    <= wdata;
      req_trans_id_o <= trans_id_i;
      req_ex_cause_o <= cause;
    end
  end

  // A flush cycle never hands a request to execute
  assert property (@(posedge clk_i) disable iff (!rst_ni) flush_i |=> !req_valid_o)
    else $error("request accepted during flush");

endmodule

`default_nettype wire

//--- lsu_mem_access.sv
/*
 * LSU execute stage
 * Private byte-enabled data memory, direct store writes and
 * registered word reads forwarded with the request fields
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_access #(
  parameter int unsigned MEM_BYTES = lsu_pkg::MEM_BYTES
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                req_valid_i,
  input  logic                req_we_i,
  input  lsu_pkg::lsu_op_e    req_op_i,
  input  lsu_pkg::word_t      req_addr_i,
  input  lsu_pkg::be_t        req_be_i,
  input  lsu_pkg::word_t      req_wdata_i,
  input  lsu_pkg::trans_id_t  req_trans_id_i,
  input  logic                req_ex_valid_i,
  input  lsu_pkg::cause_t     req_ex_cause_i,
  output logic                rd_valid_o,
  output lsu_pkg::word_t      rd_word_o,
  output lsu_pkg::lsu_op_e    rd_op_o,
  output logic [1:0]          rd_offset_o,
  output lsu_pkg::trans_id_t  rd_trans_id_o,
  output logic                rd_ex_valid_o,
  output lsu_pkg::cause_t     rd_ex_cause_o
);

  localparam int unsigned WORDS = MEM_BYTES / 4;
  localparam int unsigned IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

  lsu_pkg::word_t    mem_q [WORDS];
  lsu_pkg::word_t    merged;
  logic [IDX_W-1:0]  idx;
  logic              wr_en;

  assign idx = req_addr_i[IDX_W+1:2];
  // A store caught by flush in this stage is dropped
  assign wr_en = req_valid_i & req_we_i & ~req_ex_valid_i & ~flush_i;

  // Addressed word with the enabled store lanes merged in
  always_comb begin
    merged = mem_q[idx];
    for (int i = 0; i < lsu_pkg::XLEN / 8; i++) begin
      if (wr_en && req_be_i[i]) begin
        merged[8*i +: 8] = req_wdata_i[8*i +: 8];
      end
    end
  end

  // ------------------------------------------------
  // Data memory
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (wr_en) begin
      mem_q[idx] <= merged;
    end
  end

  // Forward to the result stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o    <= 1'b0;
      rd_ex_valid_o <= 1'b0;
    end else begin
      rd_valid_o    <= req_valid_i & ~flush_i;
      rd_ex_valid_o <= req_valid_i & req_ex_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rd_word_o     <= merged;
      rd_op_o       <= req_op_i;
      rd_offset_o   <= req_addr_i[1:0];
      rd_trans_id_o <= req_trans_id_i;
      rd_ex_cause_o <= req_ex_cause_i;
    end
  end

  // Decode never sends a clean store without lanes
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && req_we_i && !req_ex_valid_i) |-> (req_be_i != '0))
    else $error("store without byte enables");

endmodule

`default_nettype wire

//--- lsu_pkg.sv
/*
 * Load-store unit package
 * Data widths, operation and size encodings, exception causes
 * and small decode helpers shared by the LSU stages
 */
`default_nettype none

package lsu_pkg;

  localparam int unsigned XLEN      = 32;
  // Default size of the private data memory in bytes
  localparam int unsigned MEM_BYTES = 1024;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [XLEN/8-1:0] be_t;
  typedef logic [2:0]        trans_id_t;
  typedef logic [3:0]        cause_t;

  typedef enum logic [3:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // RISC-V mcause encodings for data accesses
  localparam cause_t CAUSE_LD_MISALIGNED = 4'd4;
  localparam cause_t CAUSE_LD_ACCESS     = 4'd5;
  localparam cause_t CAUSE_ST_MISALIGNED = 4'd6;
  localparam cause_t CAUSE_ST_ACCESS     = 4'd7;

  // Transfer size of an operation
  function automatic size_e op_size(lsu_op_e op);
    case (op)
      LB, LBU, SB: op_size = SIZE_BYTE;
      LH, LHU, SH: op_size = SIZE_HALF;
      default:     op_size = SIZE_WORD;
    endcase
  endfunction

  function automatic logic op_is_store(lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

endpackage

`default_nettype wire

//--- lsu_result.sv
/*
 * LSU result stage
 * Load data extraction with sign or zero extension and a
 * configurable return pipeline cleared by flush
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_result #(
  parameter int unsigned PIPE_DEPTH = 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                rd_valid_i,
  input  lsu_pkg::word_t      rd_word_i,
  input  lsu_pkg::lsu_op_e    rd_op_i,
  input  logic [1:0]          rd_offset_i,
  input  lsu_pkg::trans_id_t  rd_trans_id_i,
  input  logic                rd_ex_valid_i,
  input  lsu_pkg::cause_t     rd_ex_cause_i,
  output logic                result_valid_o,
  output lsu_pkg::trans_id_t  result_trans_id_o,
  output lsu_pkg::word_t      result_o,
  output logic                ex_valid_o,
  output lsu_pkg::cause_t     ex_cause_o
);

  localparam int unsigned EXT_W = lsu_pkg::XLEN - 8;

  lsu_pkg::word_t      lane;
  lsu_pkg::word_t      ld_data;
  logic [PIPE_DEPTH-1:0] valid_q;
  logic [PIPE_DEPTH-1:0] ex_q;
  lsu_pkg::trans_id_t  id_q    [PIPE_DEPTH];
  lsu_pkg::word_t      data_q  [PIPE_DEPTH];
  lsu_pkg::cause_t     cause_q [PIPE_DEPTH];

  // Shift the addressed byte or half down to lane 0
  assign lane = rd_word_i >> {rd_offset_i, 3'b000};

  // Stores and faults return zero
  always_comb begin
    ld_data = '0;
    if (!rd_ex_valid_i && !lsu_pkg::op_is_store(rd_op_i)) begin
      case (lsu_pkg::op_size(rd_op_i))
        lsu_pkg::SIZE_BYTE: begin
          ld_data = (rd_op_i == lsu_pkg::LB) ? {{EXT_W{lane[7]}}, lane[7:0]}
                                             : {{EXT_W{1'b0}}, lane[7:0]};
        end
        lsu_pkg::SIZE_HALF: begin
          ld_data = (rd_op_i == lsu_pkg::LH) ? {{(EXT_W-8){lane[15]}}, lane[15:0]}
                                             : {{(EXT_W-8){1'b0}}, lane[15:0]};
        end
        default: begin
          ld_data = rd_word_i;
        end
      endcase
    end
  end

  // ------------------------------------------------
  // Return pipeline
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      ex_q    <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
      ex_q    <= '0;
    end else begin
      valid_q[0] <= rd_valid_i;
      ex_q[0]    <= rd_valid_i & rd_ex_valid_i;
      for (int s = 1; s < PIPE_DEPTH; s++) begin
        valid_q[s] <= valid_q[s-1];
        ex_q[s]    <= ex_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    id_q[0]    <= rd_trans_id_i;
    data_q[0]  <= ld_data;
    cause_q[0] <= rd_ex_cause_i;
    for (int s = 1; s < PIPE_DEPTH; s++) begin
      id_q[s]    <= id_q[s-1];
      data_q[s]  <= data_q[s-1];
      cause_q[s] <= cause_q[s-1];
    end
  end

  assign result_valid_o    = valid_q[PIPE_DEPTH-1];
  assign result_trans_id_o = id_q[PIPE_DEPTH-1];
  assign result_o          = data_q[PIPE_DEPTH-1];
  assign ex_valid_o        = ex_q[PIPE_DEPTH-1];
  assign ex_cause_o        = cause_q[PIPE_DEPTH-1];

  // Valid chain is fully defined once reset is released
  assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(result_valid_o))
    else $error("result valid unknown");

endmodule

`default_nettype wire

//--- lsu_top.sv
/*
 * Load-store unit top level
 * Decode, execute and result stages with one tagged result port
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int unsigned MEM_BYTES  = lsu_pkg::MEM_BYTES,
  parameter int unsigned PIPE_DEPTH = 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  lsu_pkg::lsu_op_e    op_i,
  input  lsu_pkg::word_t      operand_a_i,
  input  lsu_pkg::word_t      operand_b_i,
  input  lsu_pkg::word_t      imm_i,
  input  lsu_pkg::trans_id_t  trans_id_i,
  output logic                result_valid_o,
  output lsu_pkg::trans_id_t  result_trans_id_o,
  output lsu_pkg::word_t      result_o,
  output logic                ex_valid_o,
  output lsu_pkg::cause_t     ex_cause_o
);

  // Decode to execute
  logic                req_valid;
  logic                req_we;
  lsu_pkg::lsu_op_e    req_op;
  lsu_pkg::word_t      req_addr;
  lsu_pkg::be_t        req_be;
  lsu_pkg::word_t      req_wdata;
  lsu_pkg::trans_id_t  req_trans_id;
  logic                req_ex_valid;
  lsu_pkg::cause_t     req_ex_cause;

  // Execute to result
  logic                rd_valid;
  lsu_pkg::word_t      rd_word;
  lsu_pkg::lsu_op_e    rd_op;
  logic [1:0]          rd_offset;
  lsu_pkg::trans_id_t  rd_trans_id;
  logic                rd_ex_valid;
  lsu_pkg::cause_t     rd_ex_cause;

  lsu_decode #(
    .MEM_BYTES (MEM_BYTES)
  ) i_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .imm_i          (imm_i),
    .trans_id_i     (trans_id_i),
    .req_valid_o    (req_valid),
    .req_we_o       (req_we),
    .req_op_o       (req_op),
    .req_addr_o     (req_addr),
    .req_be_o       (req_be),
    .req_wdata_o    (req_wdata),
    .req_trans_id_o (req_trans_id),
    .req_ex_valid_o (req_ex_valid),
    .req_ex_cause_o (req_ex_cause)
  );

  lsu_mem_access #(
    .MEM_BYTES (MEM_BYTES)
  ) i_mem_access (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .req_valid_i    (req_valid),
    .req_we_i       (req_we),
    .req_op_i       (req_op),
    .req_addr_i     (req_addr),
    .req_be_i       (req_be),
    .req_wdata_i    (req_wdata),
    .req_trans_id_i (req_trans_id),
    .req_ex_valid_i (req_ex_valid),
    .req_ex_cause_i (req_ex_cause),
    .rd_valid_o     (rd_valid),
    .rd_word_o      (rd_word),
    .rd_op_o        (rd_op),
    .rd_offset_o    (rd_offset),
    .rd_trans_id_o  (rd_trans_id),
    .rd_ex_valid_o  (rd_ex_valid),
    .rd_ex_cause_o  (rd_ex_cause)
  );

  lsu_result #(
    .PIPE_DEPTH (PIPE_DEPTH)
  ) i_result (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .rd_valid_i        (rd_valid),
    .rd_word_i         (rd_word),
    .rd_op_i           (rd_op),
    .rd_offset_i       (rd_offset),
    .rd_trans_id_i     (rd_trans_id),
    .rd_ex_valid_i     (rd_ex_valid),
    .rd_ex_cause_i     (rd_ex_cause),
    .result_valid_o    (result_valid_o),
    .result_trans_id_o (result_trans_id_o),
    .result_o          (result_o),
    .ex_valid_o        (ex_valid_o),
    .ex_cause_o        (ex_cause_o)
  );

endmodule

`default_nettype wire

//--- tb_lsu.sv
/*
 * Load-store unit testbench
 * Directed and random memory traffic with a byte-level memory model,
 * in-order result checking, latency and flush behaviour
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  localparam int unsigned MEM_BYTES = lsu_pkg::MEM_BYTES;
  localparam int unsigned AW        = $clog2(MEM_BYTES);

  typedef struct packed {
    lsu_pkg::trans_id_t id;
    lsu_pkg::word_t     value;
    logic               ex;
    lsu_pkg::cause_t    cause;
  } expect_t;

  logic                clk_i;
  logic                rst_ni;
  logic                flush_i;
  logic                valid_i;
  logic                ready_o;
  lsu_pkg::lsu_op_e    op_i;
  lsu_pkg::word_t      operand_a_i;
  lsu_pkg::word_t      operand_b_i;
  lsu_pkg::word_t      imm_i;
  lsu_pkg::trans_id_t  trans_id_i;
  logic                result_valid_o;
  lsu_pkg::trans_id_t  result_trans_id_o;
  lsu_pkg::word_t      result_o;
  logic                ex_valid_o;
  lsu_pkg::cause_t     ex_cause_o;

  logic [7:0]          model_mem [MEM_BYTES];
  expect_t             exp_q [$];
  lsu_pkg::trans_id_t  next_id;
  string               test_name;
  int                  checks;
  int                  errors;
  int                  chk_mark;
  int                  err_mark;

  lsu_top #(
    .MEM_BYTES  (MEM_BYTES),
    .PIPE_DEPTH (1)
  ) i_lsu_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .valid_i           (valid_i),
    .ready_o           (ready_o),
    .op_i              (op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .imm_i             (imm_i),
    .trans_id_i        (trans_id_i),
    .result_valid_o    (result_valid_o),
    .result_trans_id_o (result_trans_id_o),
    .result_o          (result_o),
    .ex_valid_o        (ex_valid_o),
    .ex_cause_o        (ex_cause_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic int access_bytes(lsu_pkg::lsu_op_e op);
    case (op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
      default:                                return 4;
    endcase
  endfunction

  // Expected tag, data and exception of one access against the model memory
  function automatic expect_t ref_result(lsu_pkg::lsu_op_e op, lsu_pkg::word_t addr,
                                         lsu_pkg::trans_id_t id);
    int             nbytes;
    logic           store;
    logic           mis;
    logic           oor;
    logic [AW-1:0]  base;
    lsu_pkg::word_t raw;
    expect_t        e;
    nbytes  = access_bytes(op);
    store   = (op == lsu_pkg::SB) || (op == lsu_pkg::SH) || (op == lsu_pkg::SW);
    mis     = (addr % nbytes) != 0;
    oor     = addr >= MEM_BYTES;
    base    = addr[AW-1:0];
    e.id    = id;
    e.ex    = mis | oor;
    e.value = '0;
    e.cause = '0;
    if (mis) begin
      e.cause = store ? lsu_pkg::CAUSE_ST_MISALIGNED : lsu_pkg::CAUSE_LD_MISALIGNED;
    end else if (oor) begin
      e.cause = store ? lsu_pkg::CAUSE_ST_ACCESS : lsu_pkg::CAUSE_LD_ACCESS;
    end
    if (!e.ex && !store) begin
      raw = '0;
      for (int k = 0; k < nbytes; k++) begin
        raw[8*k +: 8] = model_mem[base + AW'(k)];
      end
      case (op)
        lsu_pkg::LB: e.value = {{24{raw[7]}}, raw[7:0]};
        lsu_pkg::LH: e.value = {{16{raw[15]}}, raw[15:0]};
        default:     e.value = raw;
      endcase
    end
    return e;
  endfunction

  task automatic write_model(input lsu_pkg::lsu_op_e op, input lsu_pkg::word_t addr,
                             input lsu_pkg::word_t data);
    logic [AW-1:0] base;
    base = addr[AW-1:0];
    for (int k = 0; k < access_bytes(op); k++) begin
      model_mem[base + AW'(k)] = data[8*k +: 8];
    end
  endtask

  // Tag, data and exception fields of one result as text
  function automatic string format_result(expect_t r);
    return $sformatf("id=%0d data=%08h ex=%0b cause=%0d", r.id, r.value, r.ex, r.cause);
  endfunction

  // ------------------------------------------------
  // Driver helpers
  // ------------------------------------------------
  task automatic abort_run(input string what);
    $display("ERROR %s: %s", test_name, what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // Present one request, wait for acceptance and record its expectation
  task automatic issue(input lsu_pkg::lsu_op_e op, input lsu_pkg::word_t base,
                       input lsu_pkg::word_t imm, input lsu_pkg::word_t data);
    int             waited;
    lsu_pkg::word_t addr;
    expect_t        e;
    waited      = 0;
    valid_i     = 1'b1;
    op_i        = op;
    operand_a_i = base;
    operand_b_i = data;
    imm_i       = imm;
    trans_id_i  = next_id;
    while (!ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > 20) abort_run("issue port never became ready");
    end
    addr = base + imm;
    e    = ref_result(op, addr, next_id);
    exp_q.push_back(e);
    if (!e.ex && (op == lsu_pkg::SB || op == lsu_pkg::SH || op == lsu_pkg::SW)) begin
      write_model(op, addr, data);
    end
    next_id++;
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > 40) abort_run("pending results never returned");
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    chk_mark  = checks;
    err_mark  = errors;
  endtask

  task automatic end_test();
    drain();
    $display("%-14s done: %0d checks, %0d errors", test_name, checks - chk_mark,
             errors - err_mark);
  endtask

  // Compare every returned result with the oldest expectation
  always @(negedge clk_i) begin
    expect_t e;
    expect_t act;
    if (rst_ni && result_valid_o) begin
      assert (exp_q.size() != 0) else begin
        $display("ERROR %s: result with tag %0d arrived with nothing pending",
                 test_name, result_trans_id_o);
        errors++;
      end
      if (exp_q.size() != 0) begin
        e   = exp_q.pop_front();
        act = {result_trans_id_o, result_o, ex_valid_o, ex_cause_o};
        checks++;
        assert (act == e) else begin
          $display("MISMATCH %s: expected %s, actual %s", test_name,
                   format_result(e), format_result(act));
          errors++;
        end
      end
    end
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  initial begin
    int               edges;
    lsu_pkg::lsu_op_e op;
    lsu_pkg::word_t   base;
    lsu_pkg::word_t   imm;
    void'($urandom(32'hbbd30854));
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = lsu_pkg::LB;
    operand_a_i = '0;
    operand_b_i = '0;
    imm_i       = '0;
    trans_id_i  = '0;
    next_id     = '0;
    checks      = 0;
    errors      = 0;
    test_name   = "reset";
    for (int i = 0; i < MEM_BYTES; i++) model_mem[i] = 8'h00;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    start_test("word_rw");
    issue(lsu_pkg::SW, 32'h30, 32'h10, 32'hdeadbeef);
    issue(lsu_pkg::LW, 32'h40, 32'h0, 32'h0);
    issue(lsu_pkg::SW, 32'h48, 32'hfffffffc, 32'h13579bdf);
    issue(lsu_pkg::LW, 32'h44, 32'h0, 32'h0);
    end_test();

    start_test("byte_half");
    issue(lsu_pkg::SW, 32'h80, 32'h0, 32'h11223344);
    issue(lsu_pkg::SB, 32'h80, 32'h1, 32'hffffffa5);
    issue(lsu_pkg::SH, 32'h80, 32'h2, 32'h00008765);
    issue(lsu_pkg::LW, 32'h80, 32'h0, 32'h0);
    issue(lsu_pkg::LB, 32'h81, 32'h0, 32'h0);
    issue(lsu_pkg::LBU, 32'h81, 32'h0, 32'h0);
    issue(lsu_pkg::LH, 32'h82, 32'h0, 32'h0);
    issue(lsu_pkg::LHU, 32'h82, 32'h0, 32'h0);
    issue(lsu_pkg::LB, 32'h80, 32'h0, 32'h0);
    end_test();

    start_test("misaligned");
    issue(lsu_pkg::SW, 32'h90, 32'h0, 32'hcafef00d);
    issue(lsu_pkg::SH, 32'h90, 32'h1, 32'h0000ffff);
    issue(lsu_pkg::SW, 32'h92, 32'h0, 32'h55555555);
    issue(lsu_pkg::LH, 32'h93, 32'h0, 32'h0);
    issue(lsu_pkg::LW, 32'h91, 32'h0, 32'h0);
    issue(lsu_pkg::LW, 32'h90, 32'h0, 32'h0);
    end_test();

    start_test("out_of_range");
    issue(lsu_pkg::LW, MEM_BYTES, 32'h0, 32'h0);
    issue(lsu_pkg::SW, MEM_BYTES, 32'h4, 32'h12345678);
    issue(lsu_pkg::SB, 32'h3f0, 32'h20, 32'h000000aa);
    issue(lsu_pkg::LH, 32'h4, 32'hfffffff8, 32'h0);
    issue(lsu_pkg::LBU, 32'h3ff, 32'h0, 32'h0);
    end_test();

    // Accept edge counts as the first edge
    start_test("latency");
    issue(lsu_pkg::LW, 32'h40, 32'h0, 32'h0);
    edges = 1;
    while (!result_valid_o) begin
      @(negedge clk_i);
      edges++;
      if (edges > 10) abort_run("single result never returned");
    end
    checks++;
    assert (edges == 3) else begin
      $display("MISMATCH %s: expected 3 actual %0d", test_name, edges);
      errors++;
    end
    end_test();

    start_test("random_stream");
    for (int i = 0; i < 200; i++) begin
      op   = lsu_pkg::lsu_op_e'(4'($urandom_range(0, 7)));
      base = 32'($urandom_range(0, 279)) * 4;
      imm  = ($urandom_range(0, 1) == 1) ? 32'h0 : 32'($urandom_range(0, 7)) - 32'd4;
      issue(op, base, imm, 32'($urandom));
    end
    end_test();

    start_test("flush");
    issue(lsu_pkg::SW, 32'h100, 32'h0, 32'h0badf00d);
    issue(lsu_pkg::SW, 32'h104, 32'h0, 32'h600dcafe);
    issue(lsu_pkg::LW, 32'h100, 32'h0, 32'h0);
    issue(lsu_pkg::LW, 32'h104, 32'h0, 32'h0);
    // A request waits on the port during the flush cycle
    flush_i     = 1'b1;
    valid_i     = 1'b1;
    op_i        = lsu_pkg::LW;
    operand_a_i = 32'h100;
    imm_i       = '0;
    #1;
    checks++;
    assert (!ready_o) else begin
      $display("ERROR %s: ready_o high while flush_i is asserted", test_name);
      errors++;
    end
    // Entries still pending at the flush edge belong to dropped items
    @(posedge clk_i);
    $display("flush discarded %0d pending results", exp_q.size());
    exp_q.delete();
    @(negedge clk_i);
    flush_i = 1'b0;
    valid_i = 1'b0;
    repeat (6) @(negedge clk_i);
    issue(lsu_pkg::LW, 32'h100, 32'h0, 32'h0);
    issue(lsu_pkg::LW, 32'h104, 32'h0, 32'h0);
    end_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
